//--- common/bus85_cfg.svh
`ifndef BUS85_CFG_SVH
`define BUS85_CFG_SVH

// ----------------------------------------
// bus widths
`define BUS85_AW 16 // address
`define BUS85_DW 8 // data, low address byte shares AD

// request side cycle kinds
`define BUS85_CYC_W 3
`define CYC_OF 3'd0 // opcode fetch
`define CYC_MR 3'd1 // memory read
`define CYC_MW 3'd2 // memory write
`define CYC_IOR 3'd3 // i/o read
`define CYC_IOW 3'd4 // i/o write

// cycle words, packed {wr_n, rd_n, iom_n, s1, s0}
// fetch strobes RD_ like a memory read, status 11 marks it
`define CW_OF 5'b10011
`define CW_MR 5'b10010
`define CW_MW 5'b01001
`define CW_IOR 5'b10110
`define CW_IOW 5'b01101

// one-hot T-state bit positions
`define TS_N 8
`define TS_TI 0 // idle
`define TS_T1 1 // address out, ALE
`define TS_T2 2
`define TS_TW 3 // wait
`define TS_T3 4
`define TS_T4 5 // fetch only
`define TS_TH 6 // hold
`define TS_TT 7 // halt

// ----------------------------------------
// SIM word bits, 2..0 are the masks
`define SIM_SOD 7
`define SIM_SDE 6
`define SIM_R75 4
`define SIM_MSE 3

// restart vectors
`define VEC_TRAP 16'h0024
`define VEC_R75 16'h003C
`define VEC_R65 16'h0034
`define VEC_R55 16'h002C

`endif

//--- common/bus85_pkg.sv
`default_nettype none

package bus85_pkg;

	// ----------------------------------------
	// strobe/status word of one machine cycle
	// raw form for compares in the FSM,
	// field form for driving single pins
	typedef union packed {
		logic [4:0] raw;
		struct packed {
			logic wr_n; // write strobe, active low
			logic rd_n; // read strobe, active low
			logic iom_n; // 1 = i/o, 0 = memory
			logic s1;
			logic s0;
		} f;
	} cycle_word_u;

endpackage

`default_nettype wire

//--- common/bus_phase_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "bus85_cfg.svh"

interface bus_phase_if;
	import bus85_pkg::*;

	logic [`TS_N-1:0] tstate; // one-hot T-state
	cycle_word_u cycle; // word of the running cycle
	logic [`BUS85_AW-1:0] addr; // latched at request
	logic [`BUS85_DW-1:0] wdata;
	logic hlda; // bus granted away

	// state machine side drives, pin side reads
	modport fsm (output tstate, cycle, addr, wdata, hlda);
	modport pins (input tstate, cycle, addr, wdata, hlda);

endinterface

`default_nettype wire

//--- tstate/tstate_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "bus85_cfg.svh"

module tstate_fsm (
	input wire clk,
	input wire rst,
	input wire i_req, // sampled in TI only
	input wire [`BUS85_CYC_W-1:0] i_cycle,
	input wire [`BUS85_AW-1:0] i_addr,
	input wire [`BUS85_DW-1:0] i_wdata,
	input wire i_ready,
	input wire i_hold,
	input wire i_halt,
	input wire i_int_pending, // wakes TT
	output logic o_done,
	bus_phase_if.fsm phase
);
	import bus85_pkg::*;

	logic [`TS_N-1:0] state, state_nx;
	logic hold_q; // hold seen in T2
	logic take; // request accepted this cycle
	logic is_io, is_of;
	cycle_word_u cyc_q, cyc_nx;
	logic [`BUS85_AW-1:0] addr_q;
	logic [`BUS85_DW-1:0] wdata_q;

	// hold wins over a request in TI
	assign take = state[`TS_TI] & i_req & ~i_hold;
	assign is_io = (i_cycle == `CYC_IOR) | (i_cycle == `CYC_IOW);
	assign is_of = (cyc_q.raw == `CW_OF); // fetch runs on into T4

	// ----------------------------------------
	// request kind to strobe/status word
	always_comb begin
		case (i_cycle)
			`CYC_OF: cyc_nx.raw = `CW_OF;
			`CYC_MR: cyc_nx.raw = `CW_MR;
			`CYC_MW: cyc_nx.raw = `CW_MW;
			`CYC_IOR: cyc_nx.raw = `CW_IOR;
			`CYC_IOW: cyc_nx.raw = `CW_IOW;
			default: cyc_nx.raw = `CW_MR; // unknown code, plain read
		endcase
	end

	// ----------------------------------------
	// next state
	always_comb begin
		state_nx = '0;
		case (1'b1)
			state[`TS_TI]: begin
				if (i_hold) state_nx[`TS_TH] = 1'b1;
				else if (take) state_nx[`TS_T1] = 1'b1;
				else if (i_halt) state_nx[`TS_TT] = 1'b1;
				else state_nx[`TS_TI] = 1'b1;
			end
			state[`TS_T1]: state_nx[`TS_T2] = 1'b1;
			state[`TS_T2], state[`TS_TW]: begin
				// low ready adds one TW per cycle
				if (i_ready) state_nx[`TS_T3] = 1'b1;
				else state_nx[`TS_TW] = 1'b1;
			end
			state[`TS_T3]: begin
				if (is_of) state_nx[`TS_T4] = 1'b1;
				else if (hold_q) state_nx[`TS_TH] = 1'b1;
				else state_nx[`TS_TI] = 1'b1;
			end
			state[`TS_T4]: begin
				if (hold_q) state_nx[`TS_TH] = 1'b1;
				else state_nx[`TS_TI] = 1'b1;
			end
			state[`TS_TH]: begin
				if (i_hold) state_nx[`TS_TH] = 1'b1;
				else state_nx[`TS_TI] = 1'b1; // hlda drops on this edge
			end
			state[`TS_TT]: begin
				if (i_hold) state_nx[`TS_TH] = 1'b1;
				else if (i_int_pending) state_nx[`TS_TI] = 1'b1;
				else state_nx[`TS_TT] = 1'b1;
			end
			default: state_nx[`TS_TI] = 1'b1; // lost one-hot, back to idle
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= `TS_N'(1) << `TS_TI;
			hold_q <= 1'b0;
			cyc_q.raw <= `CW_MR;
		end else begin
			state <= state_nx;
			if (state[`TS_T2])
				hold_q <= i_hold; // sample point for hold
			if (take)
				cyc_q <= cyc_nx;
		end
	end

	// address and write data for the whole cycle
	always_ff @(posedge clk) begin
		if (take) begin
			// port number goes out on both address bytes
			addr_q <= is_io ? {i_addr[`BUS85_DW-1:0], i_addr[`BUS85_DW-1:0]} : i_addr;
			wdata_q <= i_wdata;
		end
	end

	// done in the last state of the cycle
	assign o_done = (state[`TS_T3] & ~is_of) | state[`TS_T4];

	assign phase.tstate = state;
	assign phase.cycle = cyc_q;
	assign phase.addr = addr_q;
	assign phase.wdata = wdata_q;
	assign phase.hlda = state[`TS_TH];

endmodule

`default_nettype wire

//--- verilog/bus_pins.sv
`timescale 1ns/100ps
`default_nettype none

`include "bus85_cfg.svh"

module bus_pins (
	input wire clk,
	input wire rst,
	input wire [`BUS85_DW-1:0] i_ad, // AD bus as seen at the pins
	bus_phase_if.pins phase,
	output logic [`BUS85_DW-1:0] o_ad,
	output logic o_ad_oe,
	output logic [`BUS85_AW-1:`BUS85_DW] o_addr_hi,
	output logic o_addr_oe,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output logic o_iom_n,
	output logic o_s1,
	output logic o_s0,
	output logic o_ctl_oe,
	output logic [`BUS85_DW-1:0] o_rdata
);

	logic t1; // address phase
	logic t_strobe; // T2, TW, T3
	logic t_bus; // bus owned, T1 through T4
	logic wr_cyc;

	assign t1 = phase.tstate[`TS_T1];
	assign t_strobe = phase.tstate[`TS_T2] | phase.tstate[`TS_TW] | phase.tstate[`TS_T3];
	assign t_bus = (t1 | t_strobe | phase.tstate[`TS_T4]) & ~phase.hlda;
	assign wr_cyc = ~phase.cycle.f.wr_n;

	// ----------------------------------------
	// multiplexed AD
	assign o_ale = t1; // one cycle, low byte is valid
	assign o_ad = t1 ? phase.addr[`BUS85_DW-1:0] : phase.wdata;
	// read cycles leave AD floating after T1
	assign o_ad_oe = (t1 | (t_strobe & wr_cyc)) & ~phase.hlda;

	assign o_addr_hi = phase.addr[`BUS85_AW-1:`BUS85_DW];
	assign o_addr_oe = t_bus;

	// ----------------------------------------
	// strobes and status
	// strobes only in the data window
	assign o_rd_n = t_strobe ? phase.cycle.f.rd_n : 1'b1;
	assign o_wr_n = t_strobe ? phase.cycle.f.wr_n : 1'b1;
	// status stays up for the whole cycle
	assign o_iom_n = t_bus ? phase.cycle.f.iom_n : 1'b1;
	assign o_s1 = t_bus ? phase.cycle.f.s1 : 1'b0;
	assign o_s0 = t_bus ? phase.cycle.f.s0 : 1'b0;
	assign o_ctl_oe = t_bus; // TI, TH, TT float

	// read data taken at the end of T3
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_rdata <= '0;
		else if (phase.tstate[`TS_T3] & ~phase.cycle.f.rd_n)
			o_rdata <= i_ad;
	end

endmodule

`default_nettype wire

//--- intr/intr_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "bus85_cfg.svh"

module intr_ctrl (
	input wire clk,
	input wire rst,
	input wire i_sim_we,
	input wire [`BUS85_DW-1:0] i_sim_data,
	input wire i_ei,
	input wire i_di,
	input wire i_int_ack,
	input wire i_trap,
	input wire i_rst75,
	input wire i_rst65,
	input wire i_rst55,
	input wire i_sid,
	output logic [`BUS85_DW-1:0] o_rim_data,
	output logic o_int_pending,
	output logic [`BUS85_AW-1:0] o_int_vector,
	output logic o_sod
);

	logic [2:0] mask_q; // {m75, m65, m55} with 1 for masked
	logic ie_q, sod_q;
	logic lat75_q, trap_q; // edge latches
	logic [3:0] meta_q, sync_q; // {trap, r75, r65, r55}
	logic [1:0] last_q; // {trap, r75} edge reference
	logic trap_rise, r75_rise;
	logic p_trap, p75, p65, p55;
	logic mse, sde, r75_clr;

	// SIM word decode
	assign mse = i_sim_we & i_sim_data[`SIM_MSE];
	assign sde = i_sim_we & i_sim_data[`SIM_SDE];
	assign r75_clr = i_sim_we & i_sim_data[`SIM_R75];

	assign trap_rise = sync_q[3] & ~last_q[1];
	assign r75_rise = sync_q[2] & ~last_q[0];

	// ----------------------------------------
	// pending lines
	assign p_trap = trap_q & sync_q[3]; // edge plus level and never masked
	assign p75 = ie_q & ~mask_q[2] & lat75_q;
	assign p65 = ie_q & ~mask_q[1] & sync_q[1];
	assign p55 = ie_q & ~mask_q[0] & sync_q[0];

	assign o_int_pending = p_trap | p75 | p65 | p55;

	// priority TRAP > 7.5 > 6.5 > 5.5
	always_comb begin
		if (p_trap) o_int_vector = `VEC_TRAP;
		else if (p75) o_int_vector = `VEC_R75;
		else if (p65) o_int_vector = `VEC_R65;
		else if (p55) o_int_vector = `VEC_R55;
		else o_int_vector = '0;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mask_q <= 3'b111; // all masked out of reset
			ie_q <= 1'b0;
			sod_q <= 1'b0;
			lat75_q <= 1'b0;
			trap_q <= 1'b0;
			meta_q <= '0;
			sync_q <= '0;
			last_q <= '0;
		end else begin
			// async lines through two flops then an edge reference
			meta_q <= {i_trap, i_rst75, i_rst65, i_rst55};
			sync_q <= meta_q;
			last_q <= sync_q[3:2];
			if (mse)
				mask_q <= i_sim_data[2:0];
			if (sde)
				sod_q <= i_sim_data[`SIM_SOD];
			// ack and DI both drop IE
			if (i_int_ack | i_di)
				ie_q <= 1'b0;
			else if (i_ei)
				ie_q <= 1'b1;
			// 7.5 latch only takes edges while unmasked
			if (r75_clr | (i_int_ack & p75 & ~p_trap))
				lat75_q <= 1'b0;
			else if (r75_rise & ~mask_q[2])
				lat75_q <= 1'b1;
			if (i_int_ack & p_trap)
				trap_q <= 1'b0;
			else if (trap_rise)
				trap_q <= 1'b1;
		end
	end

	// RIM word
	assign o_rim_data = {i_sid, p75, p65, p55, ie_q, mask_q};
	assign o_sod = sod_q;

endmodule

`default_nettype wire

//--- verilog/bus85_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "bus85_cfg.svh"

module bus85_top (
	input wire clk,
	input wire rst,
	// ----------------------------------------
	// request side
	input wire i_req,
	input wire [`BUS85_CYC_W-1:0] i_cycle,
	input wire [`BUS85_AW-1:0] i_addr,
	input wire [`BUS85_DW-1:0] i_wdata,
	output wire [`BUS85_DW-1:0] o_rdata,
	output wire o_done,
	input wire i_halt,
	// ----------------------------------------
	// bus side
	input wire i_ready,
	input wire i_hold,
	output wire o_hlda,
	input wire [`BUS85_DW-1:0] i_ad,
	output wire [`BUS85_DW-1:0] o_ad,
	output wire o_ad_oe,
	output wire [`BUS85_AW-1:`BUS85_DW] o_addr_hi,
	output wire o_addr_oe,
	output wire o_ale,
	output wire o_rd_n,
	output wire o_wr_n,
	output wire o_iom_n,
	output wire o_s1,
	output wire o_s0,
	output wire o_ctl_oe,
	// ----------------------------------------
	// interrupt side
	input wire i_sim_we,
	input wire [`BUS85_DW-1:0] i_sim_data,
	input wire i_ei,
	input wire i_di,
	input wire i_int_ack,
	input wire i_trap,
	input wire i_rst75,
	input wire i_rst65,
	input wire i_rst55,
	input wire i_sid,
	output wire [`BUS85_DW-1:0] o_rim_data,
	output wire o_int_pending,
	output wire [`BUS85_AW-1:0] o_int_vector,
	output wire o_sod
);

	bus_phase_if u_phase (); // FSM to pin driver

	tstate_fsm u_fsm (
		.clk (clk),
		.rst (rst),
		.i_req (i_req),
		.i_cycle (i_cycle),
		.i_addr (i_addr),
		.i_wdata (i_wdata),
		.i_ready (i_ready),
		.i_hold (i_hold),
		.i_halt (i_halt),
		.i_int_pending (o_int_pending), // halt wake-up
		.o_done (o_done),
		.phase (u_phase.fsm)
	);

	bus_pins u_pins (
		.clk (clk),
		.rst (rst),
		.i_ad (i_ad),
		.phase (u_phase.pins),
		.o_ad (o_ad),
		.o_ad_oe (o_ad_oe),
		.o_addr_hi (o_addr_hi),
		.o_addr_oe (o_addr_oe),
		.o_ale (o_ale),
		.o_rd_n (o_rd_n),
		.o_wr_n (o_wr_n),
		.o_iom_n (o_iom_n),
		.o_s1 (o_s1),
		.o_s0 (o_s0),
		.o_ctl_oe (o_ctl_oe),
		.o_rdata (o_rdata)
	);

	intr_ctrl u_intr (
		.clk (clk),
		.rst (rst),
		.i_sim_we (i_sim_we),
		.i_sim_data (i_sim_data),
		.i_ei (i_ei),
		.i_di (i_di),
		.i_int_ack (i_int_ack),
		.i_trap (i_trap),
		.i_rst75 (i_rst75),
		.i_rst65 (i_rst65),
		.i_rst55 (i_rst55),
		.i_sid (i_sid),
		.o_rim_data (o_rim_data),
		.o_int_pending (o_int_pending),
		.o_int_vector (o_int_vector),
		.o_sod (o_sod)
	);

	assign o_hlda = u_phase.hlda; // straight from the hold state

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int HALF = 2 // 4 ns period
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #HALF o_clk = ~o_clk;
	end

	// reset held over two rising edges
	initial begin
		o_rst = 1'b1;
		repeat (2) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tb/bus85_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "bus85_cfg.svh"

module bus85_tb;

	// ----------------------------------------
	// run length budget
	localparam int MAX_WAIT = 3; // wait states 0..3
	localparam int CYC_LEN = 2 + 4 + MAX_WAIT + 1; // request edge, fetch, waits, check after
	localparam int N_BUS = 11; // bus cycles over all tests
	localparam int HOLD_LEN = 12;
	localparam int INTR_LEN = 100;
	localparam int HALT_LEN = 30;
	localparam int LIMIT = 2 * (4 + N_BUS * CYC_LEN + HOLD_LEN + INTR_LEN + HALT_LEN);

	logic clk, rst;
	logic i_req, i_halt, i_ready, i_hold;
	logic [`BUS85_CYC_W-1:0] i_cycle;
	logic [`BUS85_AW-1:0] i_addr;
	logic [`BUS85_DW-1:0] i_wdata, i_ad, i_sim_data;
	logic i_sim_we, i_ei, i_di, i_int_ack;
	logic i_trap, i_rst75, i_rst65, i_rst55, i_sid;
	wire [`BUS85_DW-1:0] o_rdata, o_ad, o_rim_data;
	wire [`BUS85_AW-1:`BUS85_DW] o_addr_hi;
	wire [`BUS85_AW-1:0] o_int_vector;
	wire o_done, o_hlda, o_ad_oe, o_addr_oe, o_ale;
	wire o_rd_n, o_wr_n, o_iom_n, o_s1, o_s0, o_ctl_oe;
	wire o_int_pending, o_sod;

	int cycles = 0; // since reset release
	logic [31:0] rng; // xorshift state

	tb_clock u_clk (.o_clk(clk), .o_rst(rst));

	bus85_top u_bus85_top (.*);

	// ----------------------------------------
	// helpers
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Fail at %0t ns: %s, got %0h expected %0h",
				$time, what, got, exp));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_wait(output int w);
		rng = xorshift(rng);
		w = int'(rng % (MAX_WAIT + 1));
	endtask

	task automatic settle(); // covers the 2-flop sync plus edge detect
		repeat (4) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic sim_write(input logic [7:0] data);
		@(posedge clk);
		i_sim_we <= 1'b1;
		i_sim_data <= data;
		@(posedge clk);
		i_sim_we <= 1'b0;
		@(negedge clk); // registered by now
	endtask

	task automatic ctl_pulse(input logic ei, input logic di, input logic ack);
		@(posedge clk);
		i_ei <= ei;
		i_di <= di;
		i_int_ack <= ack;
		@(posedge clk);
		{i_ei, i_di, i_int_ack} <= 3'b000;
		@(negedge clk);
	endtask

	// ----------------------------------------
	// one machine cycle, checked pin by pin
	task automatic run_cycle(input logic [`BUS85_CYC_W-1:0] kind, input logic [15:0] addr,
			input logic [7:0] wdata, input int waits, input bit raise_hold);
		logic is_rd, is_wr, is_io, is_of;
		logic [2:0] exp_stat; // {iom_n, s1, s0}
		logic [7:0] exp_hi, rdval;
		bit in_win;
		int cnt;
		is_of = (kind == `CYC_OF);
		is_io = (kind == `CYC_IOR) || (kind == `CYC_IOW);
		is_wr = (kind == `CYC_MW) || (kind == `CYC_IOW);
		is_rd = !is_wr;
		case (kind)
			`CYC_OF: exp_stat = 3'b011;
			`CYC_MR: exp_stat = 3'b010;
			`CYC_MW: exp_stat = 3'b001;
			`CYC_IOR: exp_stat = 3'b110;
			default: exp_stat = 3'b101; // i/o write
		endcase
		exp_hi = is_io ? addr[7:0] : addr[15:8]; // port byte on both halves
		rdval = addr[7:0] ^ addr[15:8] ^ 8'h5c;
		cnt = 0;
		@(posedge clk);
		i_req <= 1'b1;
		i_cycle <= kind;
		i_addr <= addr;
		i_wdata <= wdata;
		i_ad <= rdval; // memory side answer
		i_ready <= 1'b0;
		do begin
			@(posedge clk);
			cnt++;
			i_req <= 1'b0;
			i_ready <= (cnt >= 2 + waits); // seen one edge later
			if (raise_hold && cnt == 1)
				i_hold <= 1'b1; // lands before the T2 sample
			@(negedge clk);
			in_win = (cnt >= 2) && (cnt <= 3 + waits); // T2, TW, T3
			check(o_ale, cnt == 1, "ALE high in T1 only");
			check({o_iom_n, o_s1, o_s0}, exp_stat, "IO/M_ S1 S0 status");
			check(o_addr_hi, exp_hi, "high address byte");
			check({o_addr_oe, o_ctl_oe}, 2'b11, "address and control enables");
			check(o_rd_n, !(in_win && is_rd), "RD_ strobe");
			check(o_wr_n, !(in_win && is_wr), "WR_ strobe");
			if (cnt == 1) begin
				check(o_ad, addr[7:0], "AD low address byte at ALE");
				check(o_ad_oe, 1'b1, "AD driven in T1");
			end else if (in_win) begin
				check(o_ad_oe, is_wr, "AD drive in the data window");
				if (is_wr)
					check(o_ad, wdata, "AD write data");
			end
		end while (!o_done);
		check(cnt, is_of ? 4 + waits : 3 + waits, "cycles from request to done");
		@(posedge clk);
		@(negedge clk);
		check(o_done, 1'b0, "done is a single pulse");
		check({o_rd_n, o_wr_n, o_ad_oe}, 3'b110, "strobes released after the cycle");
		if (is_rd)
			check(o_rdata, rdval, "read data captured at T3");
	endtask

	// ----------------------------------------
	// directed tests
	task automatic reset_test();
		check({o_rd_n, o_wr_n, o_iom_n}, 3'b111, "strobes after reset");
		check({o_ale, o_done, o_hlda, o_ad_oe}, 4'b0000, "ALE, done, HLDA, AD enable after reset");
		check(o_rim_data, 8'b0000_0111, "RIM word after reset");
		check({o_sod, o_int_pending}, 2'b00, "SOD and pending after reset");
	endtask

	task automatic read_test();
		int w;
		for (int n = 0; n < 3; n++) begin
			next_wait(w);
			run_cycle(`CYC_MR, 16'h1234 + 16'h0111 * n, 8'h00, w, 1'b0);
		end
	endtask

	task automatic write_io_test();
		int w;
		next_wait(w);
		run_cycle(`CYC_MW, 16'h8a3f, 8'hc6, w, 1'b0);
		next_wait(w);
		run_cycle(`CYC_IOR, 16'h7e21, 8'h00, w, 1'b0);
		next_wait(w);
		run_cycle(`CYC_IOW, 16'h05b4, 8'h9d, w, 1'b0);
	endtask

	task automatic fetch_test();
		int w;
		next_wait(w);
		run_cycle(`CYC_OF, 16'h0040, 8'h00, w, 1'b0);
		next_wait(w);
		run_cycle(`CYC_OF, 16'hf7e1, 8'h00, w, 1'b0);
	endtask

	task automatic hold_test();
		int w;
		next_wait(w);
		run_cycle(`CYC_MR, 16'h4c4d, 8'h00, w, 1'b1); // hold rises mid-cycle
		check(o_hlda, 1'b1, "HLDA after the held cycle");
		check({o_ad_oe, o_addr_oe, o_ctl_oe}, 3'b000, "bus floated in hold");
		@(posedge clk);
		i_req <= 1'b1; // must be ignored in TH
		i_cycle <= `CYC_MW;
		@(posedge clk);
		i_req <= 1'b0;
		repeat (4) begin
			@(negedge clk);
			check({o_hlda, o_ale}, 2'b10, "request ignored in hold");
		end
		@(posedge clk);
		i_hold <= 1'b0;
		@(negedge clk);
		check(o_hlda, 1'b1, "HLDA held until the next edge");
		@(negedge clk);
		check(o_hlda, 1'b0, "HLDA dropped after hold");
		next_wait(w);
		run_cycle(`CYC_MR, 16'hb00f, 8'h00, w, 1'b0);
	endtask

	task automatic intr_test();
		sim_write(8'b0000_1101); // MSE with 7.5 and 5.5 masked
		check(o_rim_data, 8'b0000_0101, "RIM masks after SIM");
		sim_write(8'b0000_1000); // unmask all
		ctl_pulse(1'b1, 1'b0, 1'b0);
		check(o_rim_data[3], 1'b1, "IE after EI");
		@(posedge clk);
		i_rst55 <= 1'b1;
		i_rst65 <= 1'b1;
		settle();
		check(o_int_vector, 16'h0034, "6.5 over 5.5");
		@(posedge clk);
		i_rst75 <= 1'b1;
		settle();
		check(o_int_vector, 16'h003c, "7.5 over 6.5");
		@(posedge clk);
		i_trap <= 1'b1;
		settle();
		check(o_int_vector, 16'h0024, "TRAP over all");
		@(posedge clk);
		i_trap <= 1'b0;
		settle();
		check(o_int_vector, 16'h003c, "TRAP needs its level");
		sim_write(8'b0000_1100); // mask 7.5
		check(o_int_vector, 16'h0034, "masked 7.5 ignored");
		sim_write(8'b0000_1110);
		check(o_int_vector, 16'h002c, "masked 6.5 ignored");
		sim_write(8'b0000_1000);
		check(o_int_vector, 16'h003c, "7.5 still latched");
		sim_write(8'b0001_0000); // R75 only
		check(o_int_vector, 16'h0034, "R75 clears the 7.5 latch");
		check(o_rim_data, 8'b0011_1000, "RIM pending bits");
		// fresh 7.5 edge then acknowledge it
		@(posedge clk);
		i_rst75 <= 1'b0;
		settle();
		@(posedge clk);
		i_rst75 <= 1'b1;
		settle();
		check(o_int_vector, 16'h003c, "new 7.5 edge latched");
		ctl_pulse(1'b0, 1'b0, 1'b1);
		check({o_rim_data[3], o_int_pending}, 2'b00, "acknowledge clears IE");
		ctl_pulse(1'b1, 1'b0, 1'b0);
		check(o_int_vector, 16'h0034, "acknowledge cleared the 7.5 latch");
		ctl_pulse(1'b0, 1'b1, 1'b0); // DI
		check(o_int_pending, 1'b0, "DI blocks the lines");
		sim_write(8'b1100_0000);
		check(o_sod, 1'b1, "SOD set with SDE");
		sim_write(8'b0000_0000);
		check(o_sod, 1'b1, "SOD kept without SDE");
		sim_write(8'b0100_0000);
		check(o_sod, 1'b0, "SOD cleared with SDE");
		@(posedge clk);
		i_sid <= 1'b1;
		@(negedge clk);
		check(o_rim_data[7], 1'b1, "SID in RIM");
		@(posedge clk);
		{i_sid, i_rst75, i_rst65, i_rst55} <= 4'b0000;
		settle();
	endtask

	task automatic halt_test();
		int w;
		sim_write(8'b0000_1001); // 5.5 masked
		ctl_pulse(1'b1, 1'b0, 1'b0);
		check(o_int_pending, 1'b0, "nothing pending before halt");
		@(posedge clk);
		i_halt <= 1'b1;
		@(posedge clk);
		i_halt <= 1'b0;
		i_req <= 1'b1; // lands in TT
		i_cycle <= `CYC_MR;
		i_rst55 <= 1'b1; // masked so no wake
		@(posedge clk);
		i_req <= 1'b0;
		repeat (8) begin
			@(negedge clk);
			check({o_ale, o_ctl_oe, o_ad_oe, o_int_pending}, 4'b0000, "halted bus stays idle");
		end
		sim_write(8'b0000_1000); // unmask 5.5
		check(o_int_pending, 1'b1, "unmasked 5.5 pending");
		next_wait(w);
		run_cycle(`CYC_MR, 16'h2c2c, 8'h00, w, 1'b0);
	endtask

	// ----------------------------------------
	// cycle limit
	always @(posedge clk) begin
		if (!rst) begin
			cycles <= cycles + 1;
			if (cycles >= LIMIT)
				abort_run("timeout: the tests ran past their cycle limit");
		end
	end

	initial begin
		rng = 32'h28956e0a;
		i_req <= 1'b0;
		i_halt <= 1'b0;
		i_ready <= 1'b1;
		i_hold <= 1'b0;
		i_cycle <= `CYC_MR;
		i_addr <= '0;
		i_wdata <= '0;
		i_ad <= '0;
		i_sim_we <= 1'b0;
		i_sim_data <= '0;
		{i_ei, i_di, i_int_ack} <= 3'b000;
		{i_trap, i_rst75, i_rst65, i_rst55, i_sid} <= 5'b00000;
		wait (rst == 1'b0);
		@(negedge clk);
		reset_test();
		read_test();
		write_io_test();
		fetch_test();
		hold_test();
		intr_test();
		halt_test();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- bus85.f
+incdir+common
common/bus85_pkg.sv
common/bus_phase_if.sv
tstate/tstate_fsm.sv
verilog/bus_pins.sv
intr/intr_ctrl.sv
verilog/bus85_top.sv
tb/tb_clock.sv
tb/bus85_tb.sv
